// ==== hdl/corePkg.sv ====
`default_nettype none

package corePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regPtr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic [0:0] {
        USER    = 1'b0,
        MACHINE = 1'b1
    } coreState_t;

    // ====================
    // opcodes
    // ====================
    parameter logic [6:0] ALU_R  = 7'b0110011;
    parameter logic [6:0] ALU_I  = 7'b0010011;
    parameter logic [6:0] LOAD   = 7'b0000011;
    parameter logic [6:0] STORE  = 7'b0100011;
    parameter logic [6:0] BRANCH = 7'b1100011;
    parameter logic [6:0] JAL    = 7'b1101111;
    parameter logic [6:0] JALR   = 7'b1100111;
    parameter logic [6:0] LUI    = 7'b0110111;
    parameter logic [6:0] AUIPC  = 7'b0010111;
    parameter logic [6:0] SYSTEM = 7'b1110011;

    parameter word_t       NOOP     = 32'h0000_0013;  // addi x0, x0, 0.
    parameter logic [11:0] MRET_IMM = 12'h302;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetchPkt_t;

    typedef struct packed {
        logic    regWe;
        logic    memWe;
        logic    memRe;
        logic    ecall;
        logic    imm;
        logic    jal;
        logic    lui;
        logic    auipc;
        funct3_t funct3;
        funct7_t funct7;
        regPtr_t rdPtr;
        word_t   immVal;
    } decodeCtrl_t;

    typedef struct packed {
        decodeCtrl_t ctrl;
        word_t       rs1;
        word_t       rs2;
        word_t       pc;
        word_t       instr;
    } issuePkt_t;

    typedef struct packed {
        logic    we;
        regPtr_t ptr;
        word_t   data;
    } wbPort_t;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic             i_CLK,

    input  corePkg::wbPort_t i_WB,

    input  corePkg::regPtr_t i_RS1_PTR,
    input  corePkg::regPtr_t i_RS2_PTR,
    output corePkg::word_t   o_RS1,
    output corePkg::word_t   o_RS2
);

    corePkg::word_t regs [32];

    // ====================
    // write port
    // ====================
    always_ff @(posedge i_CLK) begin
        if (i_WB.we && (i_WB.ptr != '0)) begin
            regs[i_WB.ptr] <= i_WB.data;
        end
    end

    // ====================
    // read ports
    // ====================
    always_comb begin
        if (i_RS1_PTR == '0) begin
            o_RS1 = '0;                 // x0 reads zero.
        end else begin
            o_RS1 = regs[i_RS1_PTR];
        end
    end

    always_comb begin
        if (i_RS2_PTR == '0) begin
            o_RS2 = '0;
        end else begin
            o_RS2 = regs[i_RS2_PTR];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  corePkg::word_t       i_INSTR,
    output corePkg::decodeCtrl_t o_CTRL
);

    logic [6:0]       opcode;
    corePkg::funct3_t funct3;
    corePkg::funct7_t funct7;

    logic isAluReg;
    logic isAluImm;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic isJal;
    logic isJalr;
    logic isLui;
    logic isAuipc;
    logic isSystem;
    logic isShift;

    corePkg::word_t immI;
    corePkg::word_t immS;
    corePkg::word_t immU;
    corePkg::word_t immSft;
    corePkg::word_t immCsr;

    assign opcode = i_INSTR[6:0];
    assign funct3 = i_INSTR[14:12];
    assign funct7 = i_INSTR[31:25];

    // ====================
    // opcode classes
    // ====================
    assign isAluReg = (opcode == corePkg::ALU_R);
    assign isAluImm = (opcode == corePkg::ALU_I);
    assign isLoad   = (opcode == corePkg::LOAD);
    assign isStore  = (opcode == corePkg::STORE);
    assign isBranch = (opcode == corePkg::BRANCH);
    assign isJal    = (opcode == corePkg::JAL);
    assign isJalr   = (opcode == corePkg::JALR);
    assign isLui    = (opcode == corePkg::LUI);
    assign isAuipc  = (opcode == corePkg::AUIPC);
    assign isSystem = (opcode == corePkg::SYSTEM);

    // sll, srl and sra.
    assign isShift = (isAluReg | isAluImm) && ((funct3 == 3'h1) || (funct3 == 3'h5));

    // ====================
    // immediates
    // ====================
    assign immI   = {{20{i_INSTR[31]}}, i_INSTR[31:20]};
    assign immS   = {{20{i_INSTR[31]}}, i_INSTR[31:25], i_INSTR[11:7]};
    assign immU   = {i_INSTR[31:12], 12'b0};
    assign immSft = {27'b0, i_INSTR[24:20]};
    assign immCsr = {20'b0, i_INSTR[31:20]};

    always_comb begin
        o_CTRL.regWe = isAluReg | isAluImm | isLoad | isJal | isJalr
                     | isLui | isAuipc | isSystem;
        o_CTRL.memWe = isStore;
        o_CTRL.memRe = isLoad;
        o_CTRL.ecall = isSystem;
        o_CTRL.imm   = ~(isAluReg | isBranch);
        o_CTRL.jal   = isJal | isJalr;
        o_CTRL.lui   = isLui;
        o_CTRL.auipc = isAuipc;

        if (isAluReg | isAluImm | isSystem | isLoad | isStore) begin
            o_CTRL.funct3 = funct3;
        end else begin
            o_CTRL.funct3 = '0;
        end
        o_CTRL.funct7 = isAluReg ? funct7 : '0;
        o_CTRL.rdPtr  = i_INSTR[11:7];

        if (isLui | isAuipc) begin
            o_CTRL.immVal = immU;
        end else if (isStore) begin
            o_CTRL.immVal = immS;
        end else if (isJal | isJalr) begin
            o_CTRL.immVal = 32'd4;      // link offset.
        end else if (isSystem) begin
            o_CTRL.immVal = immCsr;
        end else if (isShift) begin
            o_CTRL.immVal = immSft;
        end else begin
            o_CTRL.immVal = immI;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pcControl.sv ====
`timescale 1ns/10ps
`default_nettype none

module pcControl #(
    parameter corePkg::word_t RESET_PC = '0
) (
    input  logic                i_CLK,
    input  logic                i_RSTn,

    input  logic                i_ADVANCE,
    input  logic                i_IRQ,
    input  corePkg::fetchPkt_t  i_FETCH,
    input  corePkg::word_t      i_MTVEC,
    input  corePkg::word_t      i_MEPC,
    input  corePkg::word_t      i_RS1,
    input  corePkg::word_t      i_RS2,

    output corePkg::word_t      o_INSTR,
    output corePkg::word_t      o_PC,
    output corePkg::coreState_t o_CORE_STATE
);

    corePkg::coreState_t state;
    corePkg::coreState_t stateNext;
    corePkg::word_t      pc;
    corePkg::word_t      pcNext;
    corePkg::word_t      immJ;
    corePkg::word_t      immB;
    corePkg::word_t      immI;
    logic [6:0]          opcode;
    logic                enterTrap;
    logic                leaveTrap;
    logic                isMret;
    logic                taken;

    // ====================
    // trap state
    // ====================
    assign enterTrap = i_IRQ && (state == corePkg::USER);
    assign o_INSTR   = enterTrap ? corePkg::NOOP : i_FETCH.instr;
    assign opcode    = o_INSTR[6:0];
    assign isMret    = (opcode == corePkg::SYSTEM) && (o_INSTR[31:20] == corePkg::MRET_IMM);
    assign leaveTrap = isMret && (state == corePkg::MACHINE);

    always_comb begin
        case (state)
            corePkg::USER:    stateNext = enterTrap ? corePkg::MACHINE : corePkg::USER;
            corePkg::MACHINE: stateNext = leaveTrap ? corePkg::USER : corePkg::MACHINE;
            default:          stateNext = corePkg::USER;
        endcase
    end

    // ====================
    // branch compare
    // ====================
    always_comb begin
        case (o_INSTR[14:12])
            3'h0:    taken = (i_RS1 == i_RS2);
            3'h1:    taken = (i_RS1 != i_RS2);
            3'h4:    taken = ($signed(i_RS1) < $signed(i_RS2));
            3'h5:    taken = ($signed(i_RS1) >= $signed(i_RS2));
            3'h6:    taken = (i_RS1 < i_RS2);
            3'h7:    taken = (i_RS1 >= i_RS2);
            default: taken = 1'b0;
        endcase
    end

    assign immJ = {{12{o_INSTR[31]}}, o_INSTR[19:12], o_INSTR[20], o_INSTR[30:21], 1'b0};
    assign immB = {{20{o_INSTR[31]}}, o_INSTR[7], o_INSTR[30:25], o_INSTR[11:8], 1'b0};
    assign immI = {{20{o_INSTR[31]}}, o_INSTR[31:20]};

    always_comb begin
        if (enterTrap) begin
            pcNext = i_MTVEC;
        end else if (leaveTrap) begin
            pcNext = i_MEPC;
        end else if (opcode == corePkg::JAL) begin
            pcNext = pc + immJ;
        end else if (opcode == corePkg::JALR) begin
            pcNext = i_RS1 + immI;
        end else if ((opcode == corePkg::BRANCH) && taken) begin
            pcNext = pc + immB;
        end else begin
            pcNext = pc + 32'd4;
        end
    end

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            state <= corePkg::USER;
            pc    <= RESET_PC;
        end else if (i_ADVANCE) begin  // moves once per consumed instruction.
            state <= stateNext;
            pc    <= pcNext;
        end
    end

    assign o_PC         = pc;
    assign o_CORE_STATE = state;

endmodule

`default_nettype wire

// ==== hdl/decodeIssue.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeIssue #(
    parameter int ISSUE_CREDITS = 2
) (
    input  logic                 i_CLK,
    input  logic                 i_RSTn,

    input  logic                 i_FETCH_VALID,
    input  corePkg::fetchPkt_t   i_FETCH,
    input  corePkg::word_t       i_INSTR,
    input  corePkg::decodeCtrl_t i_CTRL,
    input  corePkg::word_t       i_RS1,
    input  corePkg::word_t       i_RS2,

    input  logic                 i_ISSUE_CREDIT,

    output logic                 o_ADVANCE,
    output logic                 o_ISSUE_VALID,
    output corePkg::issuePkt_t   o_ISSUE,
    output logic                 o_FETCH_CREDIT
);

    localparam int CNT_W = $clog2(ISSUE_CREDITS + 1);

    logic [CNT_W-1:0]   creditCnt;
    corePkg::issuePkt_t issueNext;

    // ====================
    // execute credits
    // ====================
    // a credit coming back this cycle can be spent at once.
    assign o_ADVANCE = i_FETCH_VALID && ((creditCnt != '0) || i_ISSUE_CREDIT);

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            creditCnt <= CNT_W'(ISSUE_CREDITS);
        end else begin
            creditCnt <= creditCnt + CNT_W'(i_ISSUE_CREDIT) - CNT_W'(o_ADVANCE);
        end
    end

    // ====================
    // issue register
    // ====================
    always_comb begin
        issueNext.ctrl  = i_CTRL;
        issueNext.rs1   = i_RS1;
        issueNext.rs2   = i_RS2;
        issueNext.pc    = i_FETCH.pc;
        issueNext.instr = i_INSTR;      // NOOP when a trap is taken.
    end

    always_ff @(posedge i_CLK) begin
        if (!i_RSTn) begin
            o_ISSUE_VALID  <= 1'b0;
            o_FETCH_CREDIT <= 1'b0;
        end else begin
            o_ISSUE_VALID  <= o_ADVANCE;
            o_FETCH_CREDIT <= o_ADVANCE;  // credit back to fetch.
        end
    end

    always_ff @(posedge i_CLK) begin
        if (o_ADVANCE) begin
            o_ISSUE <= issueNext;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decodeTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module decodeTop #(
    parameter int             ISSUE_CREDITS = 2,
    parameter corePkg::word_t RESET_PC      = '0
) (
    input  logic                i_CLK,
    input  logic                i_RSTn,

    input  logic                i_FETCH_VALID,
    input  corePkg::fetchPkt_t  i_FETCH,
    output logic                o_FETCH_CREDIT,

    input  logic                i_IRQ,
    input  corePkg::word_t      i_MTVEC,
    input  corePkg::word_t      i_MEPC,

    input  corePkg::wbPort_t    i_WB,

    input  logic                i_ISSUE_CREDIT,
    output logic                o_ISSUE_VALID,
    output corePkg::issuePkt_t  o_ISSUE,

    output corePkg::word_t      o_PC,
    output corePkg::coreState_t o_CORE_STATE
);

    corePkg::word_t       instr;
    corePkg::word_t       rs1;
    corePkg::word_t       rs2;
    corePkg::decodeCtrl_t ctrl;
    logic                 advance;

    regFile u_regFile (
        .i_CLK      (i_CLK),
        .i_WB       (i_WB),
        .i_RS1_PTR  (instr[19:15]),
        .i_RS2_PTR  (instr[24:20]),
        .o_RS1      (rs1),
        .o_RS2      (rs2)
    );

    instrDecoder u_instrDecoder (
        .i_INSTR    (instr),
        .o_CTRL     (ctrl)
    );

    pcControl #(
        .RESET_PC   (RESET_PC)
    ) u_pcControl (
        .i_CLK        (i_CLK),
        .i_RSTn       (i_RSTn),
        .i_ADVANCE    (advance),
        .i_IRQ        (i_IRQ),
        .i_FETCH      (i_FETCH),
        .i_MTVEC      (i_MTVEC),
        .i_MEPC       (i_MEPC),
        .i_RS1        (rs1),
        .i_RS2        (rs2),
        .o_INSTR      (instr),
        .o_PC         (o_PC),
        .o_CORE_STATE (o_CORE_STATE)
    );

    decodeIssue #(
        .ISSUE_CREDITS (ISSUE_CREDITS)
    ) u_decodeIssue (
        .i_CLK          (i_CLK),
        .i_RSTn         (i_RSTn),
        .i_FETCH_VALID  (i_FETCH_VALID),
        .i_FETCH        (i_FETCH),
        .i_INSTR        (instr),
        .i_CTRL         (ctrl),
        .i_RS1          (rs1),
        .i_RS2          (rs2),
        .i_ISSUE_CREDIT (i_ISSUE_CREDIT),
        .o_ADVANCE      (advance),
        .o_ISSUE_VALID  (o_ISSUE_VALID),
        .o_ISSUE        (o_ISSUE),
        .o_FETCH_CREDIT (o_FETCH_CREDIT)
    );

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic o_CLK,
    output logic o_RSTn
);

    initial begin
        o_CLK = 1'b0;
        forever #10 o_CLK = ~o_CLK;     // 20 ns period.
    end

    initial begin
        o_RSTn = 1'b0;
        repeat (4) @(posedge o_CLK);
        @(negedge o_CLK);
        o_RSTn = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/tb_decodeTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decodeTop;

    localparam int WAIT_LIMIT = 50;
    localparam corePkg::coreState_t stU = corePkg::USER;
    localparam corePkg::coreState_t stM = corePkg::MACHINE;
    localparam corePkg::word_t MTVEC = 32'h0000_0100;
    localparam corePkg::word_t MEPC  = 32'h0000_0040;

    typedef struct packed {
        corePkg::word_t      instr;
        logic                irq;
        logic                trap;      // expect NOOP in place of instr.
        logic [7:0]          flags;
        corePkg::funct3_t    f3;
        corePkg::funct7_t    f7;
        corePkg::word_t      imm;
        corePkg::word_t      nextPc;
        corePkg::coreState_t state;
    } testVec_t;

    logic                clk;
    logic                rstN;
    logic                fetchValid;
    corePkg::fetchPkt_t  fetch;
    logic                fetchCreditOut;
    logic                irq;
    corePkg::wbPort_t    wb;
    logic                issueCredit;
    logic                issueValid;
    corePkg::issuePkt_t  issue;
    corePkg::word_t      pcOut;
    corePkg::coreState_t coreState;

    testVec_t       vecTable [$];
    corePkg::word_t regModel [32];
    corePkg::word_t pcModel;
    logic [31:0]    rngState;
    logic           holdCredits;
    logic           fetchCredit;
    logic           aborted;
    int             outstanding;
    int             errCount;
    int             testNum;
    int             testFail;

    clockGen u_clockGen (
        .o_CLK  (clk),
        .o_RSTn (rstN)
    );

    decodeTop #(
        .ISSUE_CREDITS (2),
        .RESET_PC      (32'h0)
    ) u_dut (
        .i_CLK          (clk),
        .i_RSTn         (rstN),
        .i_FETCH_VALID  (fetchValid),
        .i_FETCH        (fetch),
        .o_FETCH_CREDIT (fetchCreditOut),
        .i_IRQ          (irq),
        .i_MTVEC        (MTVEC),
        .i_MEPC         (MEPC),
        .i_WB           (wb),
        .i_ISSUE_CREDIT (issueCredit),
        .o_ISSUE_VALID  (issueValid),
        .o_ISSUE        (issue),
        .o_PC           (pcOut),
        .o_CORE_STATE   (coreState)
    );

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkWord(input string name, input corePkg::word_t got,
                             input corePkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            errCount++;
        end
    endtask

    task automatic checkCtrl(input corePkg::decodeCtrl_t got,
                             input corePkg::decodeCtrl_t exp);
        if (got !== exp) begin
            $display("ERROR o_ISSUE.ctrl: got %h expected %h", got, exp);
            errCount++;
        end
    endtask

    task automatic checkState(input corePkg::coreState_t got,
                              input corePkg::coreState_t exp);
        if (got !== exp) begin
            $display("ERROR o_CORE_STATE: got %h expected %h", got, exp);
            errCount++;
        end
    endtask

    task automatic addVec(input corePkg::word_t instr, input logic irqBit, input logic trap,
                          input logic [7:0] flags, input corePkg::funct3_t f3,
                          input corePkg::funct7_t f7, input corePkg::word_t imm,
                          input corePkg::word_t nextPc, input corePkg::coreState_t state);
        testVec_t v;
        v = '{instr, irqBit, trap, flags, f3, f7, imm, nextPc, state};
        vecTable.push_back(v);
    endtask

    // one clock, then execute returns a credit on a random schedule.
    task automatic stepCycle();
        @(posedge clk);
        @(negedge clk);
        rngState = xorshift(rngState);
        if (!holdCredits && (outstanding > 0) && rngState[0]) begin
            issueCredit = 1'b1;
            outstanding--;
        end else begin
            issueCredit = 1'b0;
        end
    endtask

    task automatic reportTest(input string what, input int errBefore);
        testNum++;
        if (errCount == errBefore) begin
            $display("test %0d %s: ok", testNum, what);
        end else begin
            testFail++;
            $display("test %0d %s: failed", testNum, what);
        end
    endtask

    // ====================
    // one table entry
    // ====================
    task automatic runEntry(input testVec_t v);
        corePkg::decodeCtrl_t expCtrl;
        corePkg::word_t       expInstr;
        int                   waitCnt;
        int                   errBefore;
        errBefore = errCount;
        waitCnt = 0;
        while (!fetchCredit && (waitCnt < WAIT_LIMIT)) begin
            stepCycle();
            waitCnt++;
            if (fetchCreditOut) fetchCredit = 1'b1;
        end
        if (!fetchCredit) begin
            $display("fetch credit never came back");
            errCount++;
            aborted = 1'b1;
            return;
        end
        fetchValid  = 1'b1;
        fetch.instr = v.instr;
        fetch.pc    = pcModel;
        irq         = v.irq;
        fetchCredit = 1'b0;
        waitCnt = 0;
        do begin
            stepCycle();
            waitCnt++;
        end while (!issueValid && (waitCnt < WAIT_LIMIT));
        if (!issueValid) begin
            $display("no issue within %0d cycles of sending %h", WAIT_LIMIT, v.instr);
            errCount++;
            aborted = 1'b1;
            return;
        end
        fetchValid = 1'b0;
        irq        = 1'b0;
        outstanding++;
        checkBit("o_FETCH_CREDIT", fetchCreditOut, 1'b1);
        if (fetchCreditOut) fetchCredit = 1'b1;

        expInstr = v.trap ? 32'h0000_0013 : v.instr;
        {expCtrl.regWe, expCtrl.memWe, expCtrl.memRe, expCtrl.ecall,
         expCtrl.imm, expCtrl.jal, expCtrl.lui, expCtrl.auipc} = v.flags;
        expCtrl.funct3 = v.f3;
        expCtrl.funct7 = v.f7;
        expCtrl.rdPtr  = expInstr[11:7];
        expCtrl.immVal = v.imm;

        checkCtrl(issue.ctrl, expCtrl);
        checkWord("o_ISSUE.rs1", issue.rs1, regModel[expInstr[19:15]]);
        checkWord("o_ISSUE.rs2", issue.rs2, regModel[expInstr[24:20]]);
        checkWord("o_ISSUE.pc", issue.pc, pcModel);
        checkWord("o_ISSUE.instr", issue.instr, expInstr);
        checkWord("o_PC", pcOut, v.nextPc);
        checkState(coreState, v.state);
        pcModel = v.nextPc;
        reportTest($sformatf("instr %h", v.instr), errBefore);
    endtask

    // ====================
    // back-pressure
    // ====================
    task automatic runBackPressure();
        testVec_t addi;
        int       errBefore;
        errBefore = errCount;
        holdCredits = 1'b1;
        stepCycle();                    // a credit already on the wire lands here.
        while (outstanding > 0) begin
            issueCredit = 1'b1;
            outstanding--;
            @(posedge clk);
            @(negedge clk);
        end
        issueCredit = 1'b0;
        addi = '{32'hFFF08393, 1'b0, 1'b0, 8'h88, 3'h0, 7'h00, 32'hFFFF_FFFF, 32'h0, stU};
        repeat (2) begin
            addi.nextPc = pcModel + 32'd4;
            if (!aborted) runEntry(addi);
        end
        if (aborted) return;
        fetchValid  = 1'b1;
        fetch.instr = addi.instr;
        fetch.pc    = pcModel;
        fetchCredit = 1'b0;
        repeat (6) begin
            stepCycle();
            checkBit("o_ISSUE_VALID", issueValid, 1'b0);
            checkBit("o_FETCH_CREDIT", fetchCreditOut, 1'b0);
            checkWord("o_PC", pcOut, pcModel);
        end
        issueCredit = 1'b1;             // one credit back from execute.
        outstanding--;
        stepCycle();
        checkBit("o_ISSUE_VALID", issueValid, 1'b1);
        checkBit("o_FETCH_CREDIT", fetchCreditOut, 1'b1);
        checkWord("o_ISSUE.pc", issue.pc, pcModel);
        checkWord("o_PC", pcOut, pcModel + 32'd4);
        fetchValid = 1'b0;
        fetchCredit = 1'b1;
        outstanding++;
        pcModel = pcModel + 32'd4;
        holdCredits = 1'b0;
        reportTest("credit back-pressure", errBefore);
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int waitCnt;
        int errBefore;
        fetchValid  = 1'b0;
        fetch       = '0;
        irq         = 1'b0;
        wb          = '0;
        issueCredit = 1'b0;
        rngState    = 32'h17a264de;
        holdCredits = 1'b0;
        fetchCredit = 1'b1;             // fetch owns one credit.
        aborted     = 1'b0;
        outstanding = 0;
        errCount    = 0;
        testNum     = 0;
        testFail    = 0;
        pcModel     = 32'h0;

        for (int i = 0; i < 32; i++) begin
            regModel[i] = 32'h0A0A_0000 | i;
        end
        regModel[0] = 32'h0;
        regModel[1] = 32'h5;
        regModel[2] = 32'hFFFF_FFFD;
        regModel[3] = 32'h5;
        regModel[4] = 32'h80;

        addVec(32'h002082B3, 0, 0, 8'h80, 3'h0, 7'h00, 32'h2, 32'h4, stU);   // add.
        addVec(32'h40300333, 0, 0, 8'h80, 3'h0, 7'h20, 32'h403, 32'h8, stU); // sub, x0.
        addVec(32'hFFF08393, 0, 0, 8'h88, 3'h0, 7'h00, 32'hFFFF_FFFF, 32'hC, stU);
        addVec(32'h00309413, 0, 0, 8'h88, 3'h1, 7'h00, 32'h3, 32'h10, stU);  // slli.
        addVec(32'h40215493, 0, 0, 8'h88, 3'h5, 7'h00, 32'h2, 32'h14, stU);  // srai.
        addVec(32'h00822503, 0, 0, 8'hA8, 3'h2, 7'h00, 32'h8, 32'h18, stU);  // lw.
        addVec(32'hFE122E23, 0, 0, 8'h48, 3'h2, 7'h00, 32'hFFFF_FFFC, 32'h1C, stU);
        addVec(32'h123455B7, 0, 0, 8'h8A, 3'h0, 7'h00, 32'h1234_5000, 32'h20, stU);
        addVec(32'h00001617, 0, 0, 8'h89, 3'h0, 7'h00, 32'h1000, 32'h24, stU);
        addVec(32'h305096F3, 0, 0, 8'h98, 3'h1, 7'h00, 32'h305, 32'h28, stU); // csrrw.
        addVec(32'h00308463, 0, 0, 8'h00, 3'h0, 7'h00, 32'h3, 32'h30, stU);  // beq taken.
        addVec(32'h00309463, 0, 0, 8'h00, 3'h0, 7'h00, 32'h3, 32'h34, stU);  // bne.
        addVec(32'hFE114CE3, 0, 0, 8'h00, 3'h0, 7'h00, 32'hFFFF_FFE1, 32'h2C, stU);
        addVec(32'h00115463, 0, 0, 8'h00, 3'h0, 7'h00, 32'h1, 32'h30, stU);  // bge.
        addVec(32'h0020E463, 0, 0, 8'h00, 3'h0, 7'h00, 32'h2, 32'h38, stU);  // bltu taken.
        addVec(32'h0020F463, 0, 0, 8'h00, 3'h0, 7'h00, 32'h2, 32'h3C, stU);  // bgeu.
        addVec(32'h010000EF, 0, 0, 8'h8C, 3'h0, 7'h00, 32'h4, 32'h4C, stU);  // jal.
        addVec(32'h02020067, 0, 0, 8'h8C, 3'h0, 7'h00, 32'h4, 32'hA0, stU);  // jalr.
        addVec(32'h002082B3, 1, 1, 8'h88, 3'h0, 7'h00, 32'h0, MTVEC, stM);   // irq.
        addVec(32'hFFF08393, 1, 0, 8'h88, 3'h0, 7'h00, 32'hFFFF_FFFF, 32'h104, stM);
        addVec(32'h30200073, 0, 0, 8'h98, 3'h0, 7'h00, 32'h302, MEPC, stU);  // mret.
        addVec(32'hFFF08393, 0, 0, 8'h88, 3'h0, 7'h00, 32'hFFFF_FFFF, 32'h44, stU);

        waitCnt = 0;
        while ((rstN !== 1'b1) && (waitCnt < WAIT_LIMIT)) begin
            @(negedge clk);
            waitCnt++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            errCount++;
            aborted = 1'b1;
        end else begin
            errBefore = errCount;
            checkBit("o_ISSUE_VALID", issueValid, 1'b0);
            checkBit("o_FETCH_CREDIT", fetchCreditOut, 1'b0);
            checkState(coreState, stU);
            checkWord("o_PC", pcOut, 32'h0);
            reportTest("reset values", errBefore);

            // x0 gets a write that must not stick.
            for (int i = 0; i < 32; i++) begin
                wb.we   = 1'b1;
                wb.ptr  = i[4:0];
                wb.data = (i == 0) ? 32'hDEAD_BEEF : regModel[i];
                @(negedge clk);
            end
            wb = '0;
        end

        foreach (vecTable[i]) begin
            if (!aborted) runEntry(vecTable[i]);
        end
        if (!aborted) runBackPressure();

        $display("tests %0d, failed %0d, mismatches %0d", testNum, testFail, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/corePkg.sv
hdl/regFile.sv
hdl/instrDecoder.sv
hdl/pcControl.sv
hdl/decodeIssue.sv
hdl/decodeTop.sv
sim/clockGen.sv
sim/tb_decodeTop.sv
